// File: verilog/ram_pkg.sv
package ram_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus and memory geometry
  ////////////////////////////////////////////////////////////////////////////

  // Data word width, one beat per word
  localparam int XLEN      = 64;
  // Physical address width
  localparam int PLEN      = 16;
  // Number of RAM words
  localparam int RAM_WORDS = 256;

  // Byte lanes per word
  localparam int BE_W      = XLEN / 8;
  // Address bits below the word index
  localparam int WORD_LSB  = $clog2(BE_W);
  // Word index width
  localparam int RAM_AW    = $clog2(RAM_WORDS);

  ////////////////////////////////////////////////////////////////////////////
  // Beat request, burst generator to RAM
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    // One cycle per beat
    logic            req;
    logic            we;
    // Byte lane enables
    logic [BE_W-1:0] be;
    logic [PLEN-1:0] addr;
    // Write data sampled with the beat
    logic [XLEN-1:0] data;
  } ram_req_t;

endpackage

// File: verilog/biu_pkg.sv
package biu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // BIU encodings
  ////////////////////////////////////////////////////////////////////////////

  // Transfer size, QWORD and above unsupported on a 64-bit bus
  typedef enum logic [2:0] {
    SIZE_BYTE  = 3'b000,
    SIZE_HWORD = 3'b001,
    SIZE_WORD  = 3'b010,
    SIZE_DWORD = 3'b011,
    SIZE_QWORD = 3'b100
  } biu_size_e;

  // Burst type, same codes as HBURST
  typedef enum logic [2:0] {
    BURST_SINGLE = 3'b000,
    BURST_INCR   = 3'b001,
    BURST_WRAP4  = 3'b010,
    BURST_INCR4  = 3'b011,
    BURST_WRAP8  = 3'b100,
    BURST_INCR8  = 3'b101,
    BURST_WRAP16 = 3'b110,
    BURST_INCR16 = 3'b111
  } biu_burst_e;

  // Decoded command, decoder to burst generator
  typedef struct packed {
    logic [ram_pkg::PLEN-1:0] addr;
    logic                     we;
    biu_size_e                size;
    biu_burst_e               burst;
    // Remaining beats after the first
    logic [3:0]               cnt;
    logic                     valid;
  } biu_cmd_t;

  ////////////////////////////////////////////////////////////////////////////
  // Conversions
  ////////////////////////////////////////////////////////////////////////////

  // Beat count minus one
  function automatic logic [3:0] burst_len_f(input biu_burst_e burst);
    case (burst)
      BURST_WRAP4, BURST_INCR4:   return 4'd3;
      BURST_WRAP8, BURST_INCR8:   return 4'd7;
      BURST_WRAP16, BURST_INCR16: return 4'd15;
      // Undefined-length INCR runs as a single beat
      default:                    return 4'd0;
    endcase
  endfunction

  // Sizes that fit in one data word
  function automatic logic size_valid_f(input biu_size_e size);
    return size <= SIZE_DWORD;
  endfunction

  // Lane mask for the size, shifted to the byte offset
  function automatic logic [ram_pkg::BE_W-1:0] byte_en_f(
    input biu_size_e                    size,
    input logic [ram_pkg::WORD_LSB-1:0] offs
  );
    logic [ram_pkg::BE_W-1:0] lanes;
    case (size)
      SIZE_BYTE:  lanes = 'h1;
      SIZE_HWORD: lanes = 'h3;
      SIZE_WORD:  lanes = 'hf;
      default:    lanes = '1;
    endcase
    return lanes << offs;
  endfunction

endpackage

// File: verilog/biu_cmd_decode.sv
`timescale 1ns/1ps

module biu_cmd_decode (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     stb_i,
  input  logic [ram_pkg::PLEN-1:0] adr_i,
  input  biu_pkg::biu_size_e       size_i,
  input  biu_pkg::biu_burst_e      type_i,
  input  logic                     we_i,
  // Burst generator still active
  input  logic                     busy_i,
  output logic                     stb_ack_o,
  output logic                     err_o,
  output biu_pkg::biu_cmd_t        cmd_o
);

  import biu_pkg::*;

  // Strobe taken this edge
  logic accept;
  // Size and burst length disagree
  logic bad_cmd;

  ////////////////////////////////////////////////////////////////////////////
  // Acceptance
  ////////////////////////////////////////////////////////////////////////////

  // Free only when nothing held here and no burst running
  assign stb_ack_o = ~cmd_o.valid & ~busy_i;
  assign accept    = stb_i & stb_ack_o;

  // Multi-beat bursts need full doublewords
  assign bad_cmd = ~size_valid_f(size_i) |
                   ((burst_len_f(type_i) != 4'd0) & (size_i != SIZE_DWORD));

  ////////////////////////////////////////////////////////////////////////////
  // Command register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst) begin
    if (~rst) begin
      cmd_o <= '0;
      err_o <= 1'b0;
    end else begin
      // Both are single-cycle pulses
      err_o       <= accept & bad_cmd;
      cmd_o.valid <= accept & ~bad_cmd;
      if (accept) begin
        cmd_o.addr  <= adr_i;
        cmd_o.we    <= we_i;
        cmd_o.size  <= size_i;
        cmd_o.burst <= type_i;
        cmd_o.cnt   <= burst_len_f(type_i);
      end
    end
  end

endmodule

// File: verilog/biu_burst_gen.sv
`timescale 1ns/1ps

module biu_burst_gen (
  input  logic                     clk,
  input  logic                     rst,
  input  biu_pkg::biu_cmd_t        cmd_i,
  input  logic [ram_pkg::XLEN-1:0] d_i,
  output logic                     busy_o,
  output logic                     d_ack_o,
  output ram_pkg::ram_req_t        req_o
);

  import biu_pkg::*;
  import ram_pkg::*;

  // Next word address, wrapping inside the aligned block
  function automatic logic [PLEN-1:0] nxt_addr_f(
    input logic [PLEN-1:0] addr,
    input biu_burst_e      burst
  );
    logic [PLEN-1:0] nxt;
    nxt = {addr[PLEN-1:WORD_LSB] + (PLEN-WORD_LSB)'(1), {WORD_LSB{1'b0}}};
    case (burst)
      // 32 byte block
      BURST_WRAP4:  nxt = {addr[PLEN-1:5], nxt[4:0]};
      // 64 byte block
      BURST_WRAP8:  nxt = {addr[PLEN-1:6], nxt[5:0]};
      // 128 byte block
      BURST_WRAP16: nxt = {addr[PLEN-1:7], nxt[6:0]};
      default: ;
    endcase
    return nxt;
  endfunction

  // Beat waiting to go out at the next edge
  logic            pend_q;
  // Beats left after the pending one
  logic [3:0]      cnt_q;
  logic [PLEN-1:0] addr_q;
  biu_size_e       size_q;
  biu_burst_e      burst_q;
  logic            we_q;

  ////////////////////////////////////////////////////////////////////////////
  // Beat counter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst) begin
    if (~rst) begin
      pend_q <= 1'b0;
      cnt_q  <= '0;
    end else if (cmd_i.valid) begin
      pend_q <= 1'b1;
      cnt_q  <= cmd_i.cnt;
    end else if (pend_q) begin
      // Last beat leaves this edge
      if (cnt_q == 4'd0) begin
        pend_q <= 1'b0;
      end else begin
        cnt_q <= cnt_q - 4'd1;
      end
    end
  end

  // Burst attributes and running address
  always_ff @(posedge clk) begin
    if (cmd_i.valid) begin
      addr_q  <= cmd_i.addr;
      size_q  <= cmd_i.size;
      burst_q <= cmd_i.burst;
      we_q    <= cmd_i.we;
    end else if (pend_q && cnt_q != 4'd0) begin
      addr_q <= nxt_addr_f(addr_q, burst_q);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // RAM request
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst) begin
    if (~rst) begin
      req_o <= '0;
    end else begin
      req_o.req <= pend_q;
      if (pend_q) begin
        req_o.we   <= we_q;
        req_o.be   <= byte_en_f(size_q, addr_q[WORD_LSB-1:0]);
        req_o.addr <= addr_q;
        // Host write data sampled here
        req_o.data <= d_i;
      end
    end
  end

  // Host drives beat data while a beat is pending
  assign d_ack_o = pend_q;
  assign busy_o  = pend_q | cmd_i.valid;

endmodule

// File: verilog/biu_sram.sv
`timescale 1ns/1ps

module biu_sram (
  input  logic                     clk,
  input  logic                     rst,
  input  ram_pkg::ram_req_t        req_i,
  output logic [ram_pkg::XLEN-1:0] q_o,
  output logic [ram_pkg::PLEN-1:0] adr_o,
  output logic                     ack_o
);

  import ram_pkg::*;

  // Word storage
  logic [XLEN-1:0]   mem [RAM_WORDS];
  // Word index from address bits 10 to 3
  logic [RAM_AW-1:0] idx;

  assign idx = req_i.addr[WORD_LSB +: RAM_AW];

  ////////////////////////////////////////////////////////////////////////////
  // Array and beat response
  ////////////////////////////////////////////////////////////////////////////

  // Lane-masked write
  always_ff @(posedge clk) begin
    if (req_i.req && req_i.we) begin
      for (int i = 0; i < BE_W; i++) begin
        if (req_i.be[i]) begin
          mem[idx][8*i +: 8] <= req_i.data[8*i +: 8];
        end
      end
    end
  end

  // Read word and address travel with the ack
  always_ff @(posedge clk) begin
    if (req_i.req) begin
      q_o   <= mem[idx];
      adr_o <= req_i.addr;
    end
  end

  // One ack per request
  always_ff @(posedge clk or negedge rst) begin
    if (~rst) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= req_i.req;
    end
  end

endmodule

// File: verilog/biu_ram_bridge.sv
`timescale 1ns/1ps

module biu_ram_bridge (
  input  logic                     clk,
  input  logic                     rst,

  // BIU bus, core side
  input  logic                     biu_stb_i,
  output logic                     biu_stb_ack_o,
  output logic                     biu_d_ack_o,
  input  logic [ram_pkg::PLEN-1:0] biu_adri_i,
  output logic [ram_pkg::PLEN-1:0] biu_adro_o,
  input  biu_pkg::biu_size_e       biu_size_i,
  input  biu_pkg::biu_burst_e      biu_type_i,
  input  logic                     biu_we_i,
  input  logic [ram_pkg::XLEN-1:0] biu_d_i,
  output logic [ram_pkg::XLEN-1:0] biu_q_o,
  output logic                     biu_ack_o,
  output logic                     biu_err_o
);

  import biu_pkg::*;
  import ram_pkg::*;

  // Stage links
  biu_cmd_t cmd;
  ram_req_t req;
  logic     busy;

  ////////////////////////////////////////////////////////////////////////////
  // Stages
  ////////////////////////////////////////////////////////////////////////////

  // Stage 1, validate and register the command
  biu_cmd_decode i_cmd_decode (
    .clk       (clk),
    .rst       (rst),
    .stb_i     (biu_stb_i),
    .adr_i     (biu_adri_i),
    .size_i    (biu_size_i),
    .type_i    (biu_type_i),
    .we_i      (biu_we_i),
    .busy_i    (busy),
    .stb_ack_o (biu_stb_ack_o),
    .err_o     (biu_err_o),
    .cmd_o     (cmd)
  );

  // Stage 2, one RAM request per beat
  biu_burst_gen i_burst_gen (
    .clk     (clk),
    .rst     (rst),
    .cmd_i   (cmd),
    .d_i     (biu_d_i),
    .busy_o  (busy),
    .d_ack_o (biu_d_ack_o),
    .req_o   (req)
  );

  // Stage 3, storage and beat response
  biu_sram i_sram (
    .clk   (clk),
    .rst   (rst),
    .req_i (req),
    .q_o   (biu_q_o),
    .adr_o (biu_adro_o),
    .ack_o (biu_ack_o)
  );

endmodule

// File: test/biu_ram_bridge_assert.sv
`timescale 1ns/1ps

module biu_ram_bridge_assert (
  input logic clk,
  input logic rst,
  input logic stb_i,
  input logic stb_ack_i,
  input logic d_ack_i,
  input logic ack_i,
  input logic err_i
);

  // Error pulse and beat ack never share a cycle
  err_ack_excl : assert property (@(posedge clk) disable iff (!rst)
    !(err_i && ack_i))
    else $error("err and ack high in the same cycle");

  // Valid command, first beat data two cycles after acceptance
  d_ack_delay : assert property (@(posedge clk) disable iff (!rst)
    (stb_i && stb_ack_i) ##1 !err_i |-> ##1 $rose(d_ack_i))
    else $error("d_ack did not rise two cycles after accepted strobe");

  // Strobe ack only once the last ack of a burst is at most one cycle away
  stb_ack_busy : assert property (@(posedge clk) disable iff (!rst)
    $past(stb_ack_i, 2) |-> !ack_i)
    else $error("stb_ack high while beats pending");

endmodule

bind biu_ram_bridge biu_ram_bridge_assert i_assert (
  .clk       (clk),
  .rst       (rst),
  .stb_i     (biu_stb_i),
  .stb_ack_i (biu_stb_ack_o),
  .d_ack_i   (biu_d_ack_o),
  .ack_i     (biu_ack_o),
  .err_i     (biu_err_o)
);

// File: test/biu_ram_bridge_tb.sv
`timescale 1ns/1ps

module biu_ram_bridge_tb;

  import biu_pkg::*;
  import ram_pkg::*;

  // 200 commands of 20 cycles each
  localparam int MAX_CYCLES = 200 * 20;

  // One expected beat response
  typedef struct packed {
    int              cyc;
    logic            we;
    logic [PLEN-1:0] addr;
    logic [XLEN-1:0] data;
  } beat_t;

  logic            clk;
  logic            rst;
  logic            stb;
  logic            stb_ack;
  logic            d_ack;
  logic [PLEN-1:0] adri;
  logic [PLEN-1:0] adro;
  biu_size_e       size;
  biu_burst_e      btype;
  logic            we;
  logic [XLEN-1:0] d;
  logic [XLEN-1:0] q;
  logic            ack;
  logic            err;

  // Shadow memory and pending responses
  logic [XLEN-1:0] shadow [RAM_WORDS];
  logic [XLEN-1:0] wdata [16];
  beat_t           exp_q [$];
  int              err_q [$];
  biu_burst_e      multi [6];
  logic [31:0]     seed = 32'h17b3aa40;
  int              cyc = 0;
  int              errors = 0;
  int              ack_count = 0;
  int              expected_beats = 0;
  int              commands = 0;

  biu_ram_bridge i_biu_ram_bridge (
    .clk           (clk),
    .rst           (rst),
    .biu_stb_i     (stb),
    .biu_stb_ack_o (stb_ack),
    .biu_d_ack_o   (d_ack),
    .biu_adri_i    (adri),
    .biu_adro_o    (adro),
    .biu_size_i    (size),
    .biu_type_i    (btype),
    .biu_we_i      (we),
    .biu_d_i       (d),
    .biu_q_o       (q),
    .biu_ack_o     (ack),
    .biu_err_o     (err)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Cycle number, read on the falling edge
  always @(posedge clk) cyc <= cyc + 1;

  ////////////////////////////////////////////////////////////////////////////
  // Random numbers and reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    seed = seed ^ (seed << 13);
    seed = seed ^ (seed >> 17);
    seed = seed ^ (seed << 5);
    return seed;
  endfunction

  function automatic logic [PLEN-1:0] align(input logic [PLEN-1:0] a, input biu_size_e sz);
    return a & ~PLEN'((1 << int'(sz)) - 1);
  endfunction

  function automatic int beat_count(input biu_burst_e bt);
    case (bt)
      BURST_WRAP4, BURST_INCR4:   return 4;
      BURST_WRAP8, BURST_INCR8:   return 8;
      BURST_WRAP16, BURST_INCR16: return 16;
      default:                    return 1;
    endcase
  endfunction

  // Lanes from the offset up, dropped above lane 7
  function automatic logic [7:0] lane_mask(input biu_size_e sz, input logic [2:0] offs);
    logic [7:0] m;
    int         nb;
    nb = 1 << int'(sz);
    m  = '0;
    for (int i = 0; i < 8; i++) begin
      if (i >= int'(offs) && i < int'(offs) + nb) m[i] = 1'b1;
    end
    return m;
  endfunction

  // Queues the expected beats of one accepted command, returns the beat count
  function automatic int predict(input logic [PLEN-1:0] addr, input logic wr,
                                 input biu_size_e sz, input biu_burst_e bt, input int a_cyc);
    int              n;
    logic [PLEN-1:0] a;
    logic [PLEN-1:0] nxt;
    logic [PLEN-1:0] blk;
    logic [7:0]      be;
    beat_t           b;
    n = beat_count(bt);
    if (sz > SIZE_DWORD || (n > 1 && sz != SIZE_DWORD)) begin
      // Error pulse in the cycle after acceptance
      err_q.push_back(a_cyc);
      return 0;
    end
    a   = addr;
    blk = PLEN'(n * 8 - 1);
    for (int k = 0; k < n; k++) begin
      if (k > 0) begin
        // Start of the following 8-byte word
        nxt = (a & ~PLEN'(7)) + PLEN'(8);
        if (bt inside {BURST_WRAP4, BURST_WRAP8, BURST_WRAP16}) a = (a & ~blk) | (nxt & blk);
        else a = nxt;
      end
      be = lane_mask(sz, a[2:0]);
      for (int i = 0; i < 8; i++) begin
        if (wr && be[i]) shadow[a[10:3]][8*i +: 8] = wdata[k][8*i +: 8];
      end
      b.cyc  = a_cyc + 3 + k;
      b.we   = wr;
      b.addr = a;
      b.data = shadow[a[10:3]];
      exp_q.push_back(b);
    end
    expected_beats += n;
    return n;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Host driver
  ////////////////////////////////////////////////////////////////////////////

  // Called on a falling edge, returns on a falling edge
  task automatic issue(input logic [PLEN-1:0] addr, input logic wr,
                       input biu_size_e sz, input biu_burst_e bt);
    int n;
    int a_cyc;
    while (!stb_ack) @(negedge clk);
    for (int k = 0; k < 16; k++) wdata[k] = {next_rand(), next_rand()};
    stb   = 1'b1;
    adri  = addr;
    we    = wr;
    size  = sz;
    btype = bt;
    a_cyc = cyc + 1;
    n     = predict(addr, wr, sz, bt, a_cyc);
    commands++;
    @(negedge clk);
    stb = 1'b0;
    // One data word per d_ack
    for (int k = 0; k < n; k++) begin
      while (!d_ack) @(negedge clk);
      if (stb_ack) begin
        errors++;
        $display("Strobe ack high during a burst at t=%0t", $time);
      end
      d = wdata[k];
      @(negedge clk);
    end
    if (!stb_ack) begin
      errors++;
      $display("Strobe ack still low after the last beat at t=%0t", $time);
    end
  endtask

  task automatic drain();
    while (exp_q.size() != 0 || err_q.size() != 0) @(negedge clk);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Response checker
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    beat_t e;
    int    ec;
    if (rst && ack) begin
      ack_count++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("Ack with no beat outstanding at t=%0t", $time);
      end else begin
        e = exp_q.pop_front();
        if (cyc != e.cyc) begin
          errors++;
          $display("MISMATCH t=%0t biu_ack_o cycle exp=%0d got=%0d", $time, e.cyc, cyc);
        end
        if (adro !== e.addr) begin
          errors++;
          $display("MISMATCH t=%0t biu_adro_o exp=%h got=%h", $time, e.addr, adro);
        end
        if (!e.we && q !== e.data) begin
          errors++;
          $display("MISMATCH t=%0t biu_q_o exp=%h got=%h", $time, e.data, q);
        end
      end
    end
    if (rst && err) begin
      if (err_q.size() == 0) begin
        errors++;
        $display("Error pulse without an invalid command at t=%0t", $time);
      end else begin
        ec = err_q.pop_front();
        if (cyc != ec) begin
          errors++;
          $display("MISMATCH t=%0t biu_err_o cycle exp=%0d got=%0d", $time, ec, cyc);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0]     r;
    logic [PLEN-1:0] a;
    biu_size_e       sz;
    biu_burst_e      bt;
    rst   = 1'b0;
    stb   = 1'b0;
    adri  = '0;
    size  = SIZE_BYTE;
    btype = BURST_SINGLE;
    we    = 1'b0;
    d     = '0;
    multi = '{BURST_INCR4, BURST_INCR8, BURST_INCR16, BURST_WRAP4, BURST_WRAP8, BURST_WRAP16};
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
    @(negedge clk);
    if (!stb_ack || ack || d_ack || err) begin
      errors++;
      $display("Outputs not idle after reset at t=%0t", $time);
    end
    // Fill every word so reads have known data
    for (int i = 0; i < 16; i++) issue(PLEN'(i * 128), 1'b1, SIZE_DWORD, BURST_INCR16);
    // Single writes of each size, read back as doublewords
    for (int i = 0; i < 24; i++) begin
      r  = next_rand();
      sz = biu_size_e'({1'b0, r[1:0]});
      a  = align(r[31:16], sz);
      issue(a, 1'b1, sz, BURST_SINGLE);
      issue(align(a, SIZE_DWORD), 1'b0, SIZE_DWORD, BURST_SINGLE);
    end
    // Incrementing and wrapping bursts, start mid-block
    for (int rep = 0; rep < 2; rep++) begin
      for (int j = 0; j < 6; j++) begin
        a    = align(PLEN'(next_rand()), SIZE_DWORD);
        a[4] = 1'b1;
        issue(a, 1'b1, SIZE_DWORD, multi[j]);
        issue(a, 1'b0, SIZE_DWORD, multi[j]);
      end
    end
    // Invalid commands from an idle bus, then a read of the same word
    for (int i = 0; i < 10; i++) begin
      r = next_rand();
      a = align(r[31:16], SIZE_DWORD);
      if (r[0]) begin
        sz = biu_size_e'({1'b1, r[2:1]});
        bt = biu_burst_e'(r[5:3]);
      end else begin
        sz = (r[2:1] == 2'd3) ? SIZE_BYTE : biu_size_e'({1'b0, r[2:1]});
        bt = multi[int'(r[5:3]) % 6];
      end
      drain();
      issue(a, r[8], sz, bt);
      issue(a, 1'b0, SIZE_DWORD, BURST_SINGLE);
    end
    drain();
    // Back-to-back valid commands
    for (int i = 0; i < 40; i++) begin
      r  = next_rand();
      bt = biu_burst_e'(r[2:0]);
      sz = (beat_count(bt) > 1) ? SIZE_DWORD : biu_size_e'({1'b0, r[4:3]});
      issue(align(r[31:16], sz), r[5], sz, bt);
    end
    drain();
    if (ack_count != expected_beats) begin
      errors++;
      $display("MISMATCH t=%0t biu_ack_o count exp=%0d got=%0d", $time, expected_beats,
               ack_count);
    end
    $display("Summary: %0d commands, %0d acks, %0d errors", commands, ack_count, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (MAX_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles, the run did not complete", MAX_CYCLES);
    $display("Verification failed");
    $finish;
  end

endmodule

// File: biu_ram_bridge.f
verilog/ram_pkg.sv
verilog/biu_pkg.sv
verilog/biu_cmd_decode.sv
verilog/biu_burst_gen.sv
verilog/biu_sram.sv
verilog/biu_ram_bridge.sv
test/biu_ram_bridge_assert.sv
test/biu_ram_bridge_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP       := biu_ram_bridge_tb
FILELIST  := biu_ram_bridge.f
MDIR      := obj_dir
BIN       := $(MDIR)/V$(TOP)
PASS_MSG  := Verification passed

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -Mdir $(MDIR) --top-module $(TOP) -f $(FILELIST)

# Status comes from the pass search
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(MDIR)
